/* csr_trap_params.svh */
`ifndef CSR_TRAP_PARAMS_SVH
`define CSR_TRAP_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////////////////////////

`define CSR_ADDR_W 14
`define DATA_W 32
`define INTR_W 8
`define ECODE_W 6
`define TIMER_W 64
`define IS_W 13

//////////////////////////////////////////////////////////////////////
// Reset values
//////////////////////////////////////////////////////////////////////

`define CSR_RST_VAL 32'h0000_0000
`define TIMER_RST_VAL 64'h0

`endif

/* csr_pkg.sv */
`default_nettype none

`include "csr_trap_params.svh"

package csr_pkg;

    // CSR address map
    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00C,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // Current mode, bits 2:0 of CRMD
    typedef struct packed {
        logic       ie;
        logic [1:0] plv;
    } crmd_t;

    // Previous mode, bits 2:0 of PRMD
    typedef struct packed {
        logic       pie;
        logic [1:0] pplv;
    } prmd_t;

    // Timer configuration, full 32 bits
    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

endpackage

`default_nettype wire

/* excp_pkg.sv */
`default_nettype none

`include "csr_trap_params.svh"

package excp_pkg;

    // Exception codes, INT is used for every interrupt
    typedef enum logic [`ECODE_W-1:0] {
        ECODE_INT = 6'h00,
        ECODE_PIL = 6'h01,
        ECODE_PIS = 6'h02,
        ECODE_ALE = 6'h09,
        ECODE_SYS = 6'h0B,
        ECODE_BRK = 6'h0C,
        ECODE_INE = 6'h0D
    } ecode_e;

    typedef enum logic [1:0] {
        IDLE,
        REDIR_ENTER,
        REDIR_RETURN
    } trap_state_e;

endpackage

`default_nettype wire

/* csr_timer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_trap_params.svh"

module csr_timer
    import csr_pkg::*;
(
    input  wire logic                clk,
    input  wire logic                rst_n_i,
    input  wire logic                tcfg_we_i,
    input  wire logic [`DATA_W-1:0]  tcfg_wdata_i,
    input  wire logic                ticlr_i,
    output logic      [`TIMER_W-1:0] timer_64_o,
    output tcfg_t                    tcfg_o,
    output logic      [`DATA_W-1:0]  tval_o,
    output logic                     timer_pending_o
);

    logic [`TIMER_W-1:0] timer_64_q;
    tcfg_t               tcfg_q;
    tcfg_t               tcfg_wr;
    logic [`DATA_W-1:0]  tval_q;
    logic [`DATA_W-1:0]  reload_val;
    logic                pending_q;
    logic                timer_fire;

    assign tcfg_wr    = tcfg_t'(tcfg_wdata_i);
    assign reload_val = {tcfg_q.initval, 2'b00};
    // Countdown reached zero while running, a config write takes the cycle
    assign timer_fire = tcfg_q.en && (tval_q == '0) && !tcfg_we_i;

    // Free running stable counter
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            timer_64_q <= `TIMER_RST_VAL;
        end else begin
            timer_64_q <= timer_64_q + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Countdown timer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            tcfg_q <= '0;
            tval_q <= `CSR_RST_VAL;
        end else if (tcfg_we_i) begin
            tcfg_q <= tcfg_wr;
            if (tcfg_wr.en) begin
                tval_q <= {tcfg_wr.initval, 2'b00};
            end
        end else if (tcfg_q.en) begin
            if (tval_q != '0) begin
                tval_q <= tval_q - 1'b1;
            end else if (tcfg_q.periodic) begin
                tval_q <= reload_val;
            end else begin
                // One-shot timer stops here
                tcfg_q.en <= 1'b0;
            end
        end
    end

    // New expiry wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pending_q <= 1'b0;
        end else begin
            pending_q <= (pending_q && !ticlr_i) || timer_fire;
        end
    end

    assign timer_64_o      = timer_64_q;
    assign tcfg_o          = tcfg_q;
    assign tval_o          = tval_q;
    assign timer_pending_o = pending_q;

endmodule

`default_nettype wire

/* trap_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_trap_params.svh"

module trap_fsm
    import excp_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               excp_i,
    input  wire logic               ertn_i,
    input  wire logic [`DATA_W-1:0] eentry_i,
    input  wire logic [`DATA_W-1:0] era_i,
    output logic                    trap_enter_o,
    output logic                    trap_return_o,
    output logic                    redirect_o,
    output logic      [`DATA_W-1:0] redirect_pc_o
);

    trap_state_e        state_q;
    trap_state_e        state_d;
    logic [`DATA_W-1:0] redirect_pc_q;
    logic               accept_excp;
    logic               accept_ertn;

    // Requests only count in IDLE, exception first
    assign accept_excp = (state_q == IDLE) && excp_i;
    assign accept_ertn = (state_q == IDLE) && ertn_i && !excp_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept_excp) begin
                    state_d = REDIR_ENTER;
                end else if (accept_ertn) begin
                    state_d = REDIR_RETURN;
                end
            end
            REDIR_ENTER: state_d = IDLE;
            REDIR_RETURN: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Target is captured at acceptance, ERA before the trap touches it
    always_ff @(posedge clk) begin
        if (accept_excp) begin
            redirect_pc_q <= eentry_i;
        end else if (accept_ertn) begin
            redirect_pc_q <= era_i;
        end
    end

    assign trap_enter_o  = accept_excp;
    assign trap_return_o = accept_ertn;
    assign redirect_o    = (state_q == REDIR_ENTER) || (state_q == REDIR_RETURN);
    assign redirect_pc_o = redirect_pc_q;

endmodule

`default_nettype wire

/* csr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_trap_params.svh"

module csr_regfile
    import csr_pkg::*;
    import excp_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic                  csr_we_i,
    input  wire logic [`CSR_ADDR_W-1:0] csr_waddr_i,
    input  wire logic [`DATA_W-1:0]     csr_wdata_i,
    input  wire logic [`CSR_ADDR_W-1:0] csr_raddr_i,
    input  wire logic [`INTR_W-1:0]     intrpt_i,
    input  wire logic                  trap_enter_i,
    input  wire logic                  trap_return_i,
    input  wire logic [`ECODE_W-1:0]    excp_ecode_i,
    input  wire logic [`DATA_W-1:0]     excp_pc_i,
    input  wire tcfg_t                 tcfg_i,
    input  wire logic [`DATA_W-1:0]     tval_i,
    input  wire logic [`TIMER_W-1:0]    timer_64_i,
    input  wire logic                  timer_pending_i,
    output logic      [`DATA_W-1:0]     csr_rdata_o,
    output logic                       tcfg_we_o,
    output logic      [`DATA_W-1:0]     tcfg_wdata_o,
    output logic                       ticlr_o,
    output logic      [`DATA_W-1:0]     eentry_o,
    output logic      [`DATA_W-1:0]     era_o,
    output logic                       has_int_o
);

    localparam logic [`IS_W-1:0]   ECFG_MASK   = 13'h0BFF;
    localparam logic [`DATA_W-1:0] EENTRY_MASK = 32'hFFFF_FFC0;

    csr_addr_e          waddr;
    csr_addr_e          raddr;
    crmd_t              crmd_q;
    prmd_t              prmd_q;
    logic [`IS_W-1:0]   ecfg_q;
    logic [1:0]         estat_sw_q;
    logic [`INTR_W-1:0] intr_q;
    ecode_e             ecode_q;
    logic [`DATA_W-1:0] era_q;
    logic [`DATA_W-1:0] eentry_q;
    logic [`DATA_W-1:0] save_q [4];
    logic [`DATA_W-1:0] tid_q;
    logic [`IS_W-1:0]   estat_is;
    logic [`DATA_W-1:0] estat_rd;

    assign waddr = csr_addr_e'(csr_waddr_i);
    assign raddr = csr_addr_e'(csr_raddr_i);

    //////////////////////////////////////////////////////////////////////
    // CSR writes and trap updates
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            crmd_q     <= '0;
            prmd_q     <= '0;
            ecfg_q     <= '0;
            estat_sw_q <= '0;
            intr_q     <= '0;
            ecode_q    <= ECODE_INT;
            era_q      <= `CSR_RST_VAL;
            eentry_q   <= `CSR_RST_VAL;
            tid_q      <= `CSR_RST_VAL;
            for (int i = 0; i < 4; i++) begin
                save_q[i] <= `CSR_RST_VAL;
            end
        end else begin
            // External lines sampled every cycle
            intr_q <= intrpt_i;
            if (csr_we_i) begin
                case (waddr)
                    CSR_CRMD: crmd_q <= crmd_t'(csr_wdata_i[2:0]);
                    CSR_PRMD: prmd_q <= prmd_t'(csr_wdata_i[2:0]);
                    CSR_ECFG: ecfg_q <= csr_wdata_i[`IS_W-1:0] & ECFG_MASK;
                    CSR_ESTAT: estat_sw_q <= csr_wdata_i[1:0];
                    CSR_ERA: era_q <= csr_wdata_i;
                    CSR_EENTRY: eentry_q <= csr_wdata_i & EENTRY_MASK;
                    CSR_SAVE0: save_q[0] <= csr_wdata_i;
                    CSR_SAVE1: save_q[1] <= csr_wdata_i;
                    CSR_SAVE2: save_q[2] <= csr_wdata_i;
                    CSR_SAVE3: save_q[3] <= csr_wdata_i;
                    CSR_TID: tid_q <= csr_wdata_i;
                    default: ;
                endcase
            end
            // Trap updates come last so they override a write
            if (trap_enter_i) begin
                prmd_q.pplv <= crmd_q.plv;
                prmd_q.pie  <= crmd_q.ie;
                crmd_q.plv  <= 2'b00;
                crmd_q.ie   <= 1'b0;
                era_q       <= excp_pc_i;
                ecode_q     <= ecode_e'(excp_ecode_i);
            end else if (trap_return_i) begin
                crmd_q.plv <= prmd_q.pplv;
                crmd_q.ie  <= prmd_q.pie;
            end
        end
    end

    // Timer side strobes
    assign tcfg_we_o    = csr_we_i && (waddr == CSR_TCFG);
    assign tcfg_wdata_o = csr_wdata_i;
    assign ticlr_o      = csr_we_i && (waddr == CSR_TICLR) && csr_wdata_i[0];

    //////////////////////////////////////////////////////////////////////
    // Interrupt status and read mux
    //////////////////////////////////////////////////////////////////////

    // Bit 12 (IPI) and bit 10 are not implemented
    assign estat_is  = {1'b0, timer_pending_i, 1'b0, intr_q, estat_sw_q};
    assign estat_rd  = {10'b0, ecode_q, 3'b0, estat_is};
    assign has_int_o = crmd_q.ie && |(estat_is & ecfg_q);

    always_comb begin
        case (raddr)
            CSR_CRMD: csr_rdata_o = {29'b0, crmd_q};
            CSR_PRMD: csr_rdata_o = {29'b0, prmd_q};
            CSR_ECFG: csr_rdata_o = {19'b0, ecfg_q};
            CSR_ESTAT: csr_rdata_o = estat_rd;
            CSR_ERA: csr_rdata_o = era_q;
            CSR_EENTRY: csr_rdata_o = eentry_q;
            CSR_SAVE0: csr_rdata_o = save_q[0];
            CSR_SAVE1: csr_rdata_o = save_q[1];
            CSR_SAVE2: csr_rdata_o = save_q[2];
            CSR_SAVE3: csr_rdata_o = save_q[3];
            CSR_TID: csr_rdata_o = tid_q;
            CSR_TCFG: csr_rdata_o = tcfg_i;
            CSR_TVAL: csr_rdata_o = tval_i;
            default: csr_rdata_o = '0;
        endcase
    end

    assign eentry_o = eentry_q;
    assign era_o    = era_q;

endmodule

`default_nettype wire

/* csr_trap_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_trap_params.svh"

module csr_trap_top
    import csr_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n_i,
    input  wire logic [`INTR_W-1:0]     intrpt_i,
    input  wire logic                  csr_we_i,
    input  wire logic [`CSR_ADDR_W-1:0] csr_waddr_i,
    input  wire logic [`DATA_W-1:0]     csr_wdata_i,
    input  wire logic [`CSR_ADDR_W-1:0] csr_raddr_i,
    input  wire logic                  excp_i,
    input  wire logic [`ECODE_W-1:0]    excp_ecode_i,
    input  wire logic [`DATA_W-1:0]     excp_pc_i,
    input  wire logic                  ertn_i,
    output logic      [`DATA_W-1:0]     csr_rdata_o,
    output logic                       has_int_o,
    output logic                       redirect_o,
    output logic      [`DATA_W-1:0]     redirect_pc_o,
    output logic      [`TIMER_W-1:0]    timer_64_o
);

    // Timer <-> register file
    logic                tcfg_we;
    logic [`DATA_W-1:0]  tcfg_wdata;
    logic                ticlr;
    tcfg_t               tcfg;
    logic [`DATA_W-1:0]  tval;
    logic [`TIMER_W-1:0] timer_64;
    logic                timer_pending;

    // Trap FSM <-> register file
    logic               trap_enter;
    logic               trap_return;
    logic [`DATA_W-1:0] eentry;
    logic [`DATA_W-1:0] era;

    csr_timer csr_timer_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .tcfg_we_i      (tcfg_we),
        .tcfg_wdata_i   (tcfg_wdata),
        .ticlr_i        (ticlr),
        .timer_64_o     (timer_64),
        .tcfg_o         (tcfg),
        .tval_o         (tval),
        .timer_pending_o(timer_pending)
    );

    trap_fsm trap_fsm_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .excp_i       (excp_i),
        .ertn_i       (ertn_i),
        .eentry_i     (eentry),
        .era_i        (era),
        .trap_enter_o (trap_enter),
        .trap_return_o(trap_return),
        .redirect_o   (redirect_o),
        .redirect_pc_o(redirect_pc_o)
    );

    csr_regfile csr_regfile_inst (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .csr_we_i       (csr_we_i),
        .csr_waddr_i    (csr_waddr_i),
        .csr_wdata_i    (csr_wdata_i),
        .csr_raddr_i    (csr_raddr_i),
        .intrpt_i       (intrpt_i),
        .trap_enter_i   (trap_enter),
        .trap_return_i  (trap_return),
        .excp_ecode_i   (excp_ecode_i),
        .excp_pc_i      (excp_pc_i),
        .tcfg_i         (tcfg),
        .tval_i         (tval),
        .timer_64_i     (timer_64),
        .timer_pending_i(timer_pending),
        .csr_rdata_o    (csr_rdata_o),
        .tcfg_we_o      (tcfg_we),
        .tcfg_wdata_o   (tcfg_wdata),
        .ticlr_o        (ticlr),
        .eentry_o       (eentry),
        .era_o          (era),
        .has_int_o      (has_int_o)
    );

    assign timer_64_o = timer_64;

endmodule

`default_nettype wire

/* csr_trap_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_properties (
    input wire logic clk,
    input wire logic rst_n_i,
    input wire logic trap_enter_i,
    input wire logic trap_return_i,
    input wire logic redirect_i
);

    // Redirect exactly one cycle after an accepted request
    redirect_follows: assert property (@(posedge clk) disable iff (!rst_n_i)
        (trap_enter_i || trap_return_i) |=> redirect_i)
        else $error("redirect_o did not follow an accepted request");

    redirect_has_cause: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i |-> $past(trap_enter_i || trap_return_i))
        else $error("redirect_o without an accepted request one cycle before");

    enter_return_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(trap_enter_i && trap_return_i))
        else $error("trap_enter_o and trap_return_o high together");

    // Single cycle pulse
    redirect_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_i |=> !redirect_i)
        else $error("redirect_o high in two consecutive cycles");

endmodule

bind trap_fsm csr_trap_properties csr_trap_properties_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .trap_enter_i (trap_enter_o),
    .trap_return_i(trap_return_o),
    .redirect_i   (redirect_o)
);

`default_nettype wire

/* tb_csr_trap.sv */
`timescale 1ns/1ps
`default_nettype none

`include "csr_trap_params.svh"

module tb_csr_trap
    import csr_pkg::*;
;

    // Longest sequence is well under 500 cycles
    localparam int TIMEOUT_CYCLES = 2000;

    logic                   clk;
    logic                   rst_n_i;
    logic [`INTR_W-1:0]     intrpt_i;
    logic                   csr_we_i;
    logic [`CSR_ADDR_W-1:0] csr_waddr_i;
    logic [`DATA_W-1:0]     csr_wdata_i;
    logic [`CSR_ADDR_W-1:0] csr_raddr_i;
    logic                   excp_i;
    logic [`ECODE_W-1:0]    excp_ecode_i;
    logic [`DATA_W-1:0]     excp_pc_i;
    logic                   ertn_i;
    logic [`DATA_W-1:0]     csr_rdata_o;
    logic                   has_int_o;
    logic                   redirect_o;
    logic [`DATA_W-1:0]     redirect_pc_o;
    logic [`TIMER_W-1:0]    timer_64_o;

    // Shadow copy of the CSR state
    logic [2:0]             sh_crmd;
    logic [2:0]             sh_prmd;
    logic [`IS_W-1:0]       sh_ecfg;
    logic [1:0]             sh_estat_sw;
    logic [`INTR_W-1:0]     sh_intr;
    logic                   sh_tpend;
    logic [`ECODE_W-1:0]    sh_ecode;
    logic [`DATA_W-1:0]     sh_era;
    logic [`DATA_W-1:0]     sh_eentry;
    logic [`DATA_W-1:0]     sh_save [4];
    logic [`DATA_W-1:0]     sh_tid;
    logic [`DATA_W-1:0]     sh_tcfg;
    logic [`DATA_W-1:0]     sh_tval;
    logic                   cmp_en;
    logic [`CSR_ADDR_W-1:0] addr_list [18];
    int                     cycle_cnt = 0;

    csr_trap_top csr_trap_top_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .intrpt_i     (intrpt_i),
        .csr_we_i     (csr_we_i),
        .csr_waddr_i  (csr_waddr_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_raddr_i  (csr_raddr_i),
        .excp_i       (excp_i),
        .excp_ecode_i (excp_ecode_i),
        .excp_pc_i    (excp_pc_i),
        .ertn_i       (ertn_i),
        .csr_rdata_o  (csr_rdata_o),
        .has_int_o    (has_int_o),
        .redirect_o   (redirect_o),
        .redirect_pc_o(redirect_pc_o),
        .timer_64_o   (timer_64_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // ESTAT bits 12:0 with bits 10 and 12 unused
    function automatic logic [`IS_W-1:0] status_bits();
        return {1'b0, sh_tpend, 1'b0, sh_intr, sh_estat_sw};
    endfunction

    function automatic logic [`DATA_W-1:0] expected_rdata(input logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            CSR_CRMD: return {29'b0, sh_crmd};
            CSR_PRMD: return {29'b0, sh_prmd};
            CSR_ECFG: return {19'b0, sh_ecfg};
            CSR_ESTAT: return {10'b0, sh_ecode, 3'b0, status_bits()};
            CSR_ERA: return sh_era;
            CSR_EENTRY: return sh_eentry;
            CSR_SAVE0: return sh_save[0];
            CSR_SAVE1: return sh_save[1];
            CSR_SAVE2: return sh_save[2];
            CSR_SAVE3: return sh_save[3];
            CSR_TID: return sh_tid;
            CSR_TCFG: return sh_tcfg;
            CSR_TVAL: return sh_tval;
            default: return '0;
        endcase
    endfunction

    function automatic logic interrupt_due();
        return sh_crmd[2] && |(status_bits() & sh_ecfg);
    endfunction

    // Write masks per register
    task automatic shadow_write(input logic [`CSR_ADDR_W-1:0] addr,
                                input logic [`DATA_W-1:0] data);
        case (addr)
            CSR_CRMD: sh_crmd = data[2:0];
            CSR_PRMD: sh_prmd = data[2:0];
            CSR_ECFG: sh_ecfg = data[`IS_W-1:0] & 13'h0BFF;
            CSR_ESTAT: sh_estat_sw = data[1:0];
            CSR_ERA: sh_era = data;
            CSR_EENTRY: sh_eentry = data & 32'hFFFF_FFC0;
            CSR_SAVE0: sh_save[0] = data;
            CSR_SAVE1: sh_save[1] = data;
            CSR_SAVE2: sh_save[2] = data;
            CSR_SAVE3: sh_save[3] = data;
            CSR_TID: sh_tid = data;
            CSR_TCFG: begin
                sh_tcfg = data;
                if (data[0]) begin
                    sh_tval = {data[31:2], 2'b00};
                end
            end
            CSR_TICLR: begin
                if (data[0]) begin
                    sh_tpend = 1'b0;
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail at %0d ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display("Testbench failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // Compare process sampled mid cycle
    always @(negedge clk) begin
        if (cmp_en) begin
            check_value("csr_rdata_o", expected_rdata(csr_raddr_i), csr_rdata_o);
            check_value("has_int_o", interrupt_due(), has_int_o);
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish",
                     TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "Timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic write_csr(input logic [`CSR_ADDR_W-1:0] addr,
                             input logic [`DATA_W-1:0] data);
        @(posedge clk);
        #1;
        csr_we_i    = 1'b1;
        csr_waddr_i = addr;
        csr_wdata_i = data;
        @(posedge clk);
        #1;
        csr_we_i = 1'b0;
        shadow_write(addr, data);
    endtask

    task automatic read_csr(input logic [`CSR_ADDR_W-1:0] addr);
        @(posedge clk);
        #1;
        csr_raddr_i = addr;
    endtask

    // Polls ESTAT bit 11 for a bounded number of cycles
    task automatic wait_timer_bit(input int max_cycles);
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < max_cycles) begin
            @(posedge clk);
            #3;
            seen = csr_rdata_o[11];
            n++;
        end
        if (!seen) begin
            $display("Timer interrupt bit was not set within %0d cycles", max_cycles);
            $display("Testbench failed");
            $fatal(1, "Timer did not fire");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        int unsigned        seed_val;
        int                 n;
        logic [63:0]        t0;
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] data;
        logic [`ECODE_W-1:0] code;
        seed_val = $urandom(69);
        rst_n_i      = 1'b0;
        intrpt_i     = '0;
        csr_we_i     = 1'b0;
        csr_waddr_i  = '0;
        csr_wdata_i  = '0;
        csr_raddr_i  = '0;
        excp_i       = 1'b0;
        excp_ecode_i = '0;
        excp_pc_i    = '0;
        ertn_i       = 1'b0;
        cmp_en       = 1'b0;
        sh_crmd = '0;
        sh_prmd = '0;
        sh_ecfg = '0;
        sh_estat_sw = '0;
        sh_intr = '0;
        sh_tpend = 1'b0;
        sh_ecode = '0;
        sh_era = '0;
        sh_eentry = '0;
        sh_tid = '0;
        sh_tcfg = '0;
        sh_tval = '0;
        for (int i = 0; i < 4; i++) begin
            sh_save[i] = '0;
        end
        addr_list = '{CSR_CRMD, CSR_PRMD, CSR_ECFG, CSR_ESTAT, CSR_ERA, CSR_EENTRY,
                      CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG,
                      CSR_TVAL, CSR_TICLR, 14'h002, 14'h007, 14'h043, 14'h3FFF};

        repeat (2) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        #2;
        check_value("timer_64_o", 64'h0, timer_64_o);
        check_value("redirect_o", 1'b0, redirect_o);
        cmp_en = 1'b1;

        // CSR write and read back with TCFG kept disabled
        for (int r = 0; r < 3; r++) begin
            foreach (addr_list[i]) begin
                data = $urandom;
                if (addr_list[i] == CSR_TCFG) begin
                    data[0] = 1'b0;
                end
                write_csr(addr_list[i], data);
            end
            foreach (addr_list[i]) begin
                read_csr(addr_list[i]);
            end
        end

        // Exception entry
        write_csr(CSR_EENTRY, $urandom);
        write_csr(CSR_CRMD, {29'b0, 1'b1, 2'($urandom)});
        pc   = $urandom;
        code = 6'($urandom);
        @(posedge clk);
        #1;
        excp_i       = 1'b1;
        excp_ecode_i = code;
        excp_pc_i    = pc;
        #2;
        check_value("redirect_o", 1'b0, redirect_o);
        @(posedge clk);
        #1;
        excp_i   = 1'b0;
        sh_prmd  = sh_crmd;
        sh_crmd  = '0;
        sh_era   = pc;
        sh_ecode = code;
        #2;
        check_value("redirect_o", 1'b1, redirect_o);
        check_value("redirect_pc_o", sh_eentry, redirect_pc_o);
        @(posedge clk);
        #3;
        check_value("redirect_o", 1'b0, redirect_o);
        read_csr(CSR_CRMD);
        read_csr(CSR_PRMD);
        read_csr(CSR_ERA);
        read_csr(CSR_ESTAT);

        // Return with an exception dropped in the redirect cycle
        write_csr(CSR_PRMD, $urandom);
        write_csr(CSR_ERA, $urandom);
        @(posedge clk);
        #1;
        ertn_i = 1'b1;
        #2;
        check_value("redirect_o", 1'b0, redirect_o);
        @(posedge clk);
        #1;
        ertn_i       = 1'b0;
        sh_crmd      = sh_prmd;
        excp_i       = 1'b1;
        excp_pc_i    = $urandom;
        excp_ecode_i = 6'($urandom);
        #2;
        check_value("redirect_o", 1'b1, redirect_o);
        check_value("redirect_pc_o", sh_era, redirect_pc_o);
        @(posedge clk);
        #1;
        excp_i = 1'b0;
        #2;
        check_value("redirect_o", 1'b0, redirect_o);
        read_csr(CSR_CRMD);
        read_csr(CSR_ERA);
        read_csr(CSR_ESTAT);

        // Interrupt lines with ie set and then with ie clear
        write_csr(CSR_ESTAT, 32'h0);
        write_csr(CSR_ECFG, $urandom);
        write_csr(CSR_CRMD, 32'h4);
        read_csr(CSR_ESTAT);
        for (int i = 0; i < 24; i++) begin
            if (i == 12) begin
                write_csr(CSR_CRMD, 32'h0);
            end
            @(posedge clk);
            #1;
            intrpt_i = 8'($urandom);
            @(posedge clk);
            #1;
            sh_intr = intrpt_i;
        end
        check_value("has_int_o", 1'b0, has_int_o);

        // Timer pending seen directly on ESTAT bit 11
        cmp_en      = 1'b0;
        csr_raddr_i = CSR_ESTAT;
        n = $urandom_range(3, 10);
        write_csr(CSR_TCFG, {30'(n), 2'b01});
        repeat (4 * n) @(posedge clk);
        #3;
        check_value("csr_rdata_o[11]", 1'b0, csr_rdata_o[11]);
        wait_timer_bit(3);
        write_csr(CSR_TICLR, 32'h1);
        #2;
        check_value("csr_rdata_o[11]", 1'b0, csr_rdata_o[11]);
        write_csr(CSR_TCFG, {30'(n), 2'b11});
        wait_timer_bit(4 * n + 3);
        write_csr(CSR_TICLR, 32'h1);
        #2;
        check_value("csr_rdata_o[11]", 1'b0, csr_rdata_o[11]);
        wait_timer_bit(4 * n + 3);

        // Stable counter advances once per cycle
        @(posedge clk);
        #3;
        t0 = timer_64_o;
        n  = $urandom_range(5, 40);
        repeat (n) @(posedge clk);
        #3;
        check_value("timer_64_o delta", 64'(n), timer_64_o - t0);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

/* csr_trap.f */
+incdir+.
csr_pkg.sv
excp_pkg.sv
csr_timer.sv
trap_fsm.sv
csr_regfile.sv
csr_trap_top.sv
csr_trap_properties.sv
tb_csr_trap.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the CSR trap testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr_trap -f csr_trap.f -o tb_csr_trap

./obj_dir/tb_csr_trap
